//--- Makefile
# Verilator build for the Fp6 multiplier

VERILATOR  ?= verilator
TOP        ?= fe6_mul_tb
RTL_TOP    ?= fe6_mul_top
FLIST      ?= fe6_mul.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_STR   ?= RESULT: PASS
VFLAGS     ?= --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_STR)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- common/fe6_defines.svh
// Field width, prime, step-tag width and user-field width macros
`ifndef FE6_DEFINES_SVH
`define FE6_DEFINES_SVH

// Width of one Fp element
`define FE_W 16

// Field prime, P = 3 mod 4 so u^2+1 is irreducible
`define FE_P 16'd65519

// Tag carried on unit streams, one value per schedule step
`define TAG_W 5

// Pass-through user field on the outside stream
`define USER_W 8

`endif

//--- common/fe6_pkg.sv
// Field element types, stream struct, step and output-state enums, modular add and subtract
`default_nettype none

`include "fe6_defines.svh"

package fe6_pkg;

  typedef logic [`FE_W-1:0] fe_t;

  typedef struct packed {
    fe_t re;
    fe_t im;
  } fe2_t;

  // c0 sits in the top bits, matching the input beat order
  typedef struct packed {
    fe2_t c0;
    fe2_t c1;
    fe2_t c2;
  } fe6_t;

  typedef struct packed {
    logic               val;
    logic               sop;
    logic               eop;
    logic [`TAG_W-1:0]  tag;
    logic [`USER_W-1:0] user;
    fe_t                dat_a;
    fe_t                dat_b;
  } strm_t;

  // Karatsuba schedule, tag value equals step number
  typedef enum logic [`TAG_W-1:0] {
    STEP_AA, STEP_BB, STEP_CC,
    STEP_T0_A, STEP_T0_B, STEP_T0_MUL, STEP_T0_SUBB, STEP_T0_SUBC,
    STEP_T2_B, STEP_T2_A, STEP_T2_MUL, STEP_T2_SUBA, STEP_T2_ADDB,
    STEP_T1_B, STEP_T1_A, STEP_T1_MUL, STEP_T1_SUBA, STEP_T1_SUBB,
    STEP_C0_MNR, STEP_C0_FIN, STEP_C2_FIN, STEP_CC_MNR, STEP_C1_FIN
  } fe6_step_e;

  typedef enum logic {
    OUT_IDLE,
    OUT_SEND
  } out_state_e;

  function automatic fe_t mod_add(input fe_t a, input fe_t b);
    logic [`FE_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, `FE_P}) s = s - {1'b0, `FE_P};
    return s[`FE_W-1:0];
  endfunction

  function automatic fe_t mod_sub(input fe_t a, input fe_t b);
    logic [`FE_W:0] d;
    d = {1'b0, a} - {1'b0, b};
    // Borrow means the raw difference wrapped, fold P back in
    if (a < b) d = d + {1'b0, `FE_P};
    return d[`FE_W-1:0];
  endfunction

endpackage

`default_nettype wire

//--- fe6_mul.f
+incdir+common
common/fe6_pkg.sv
src/fe_addsub.sv
src/fe2_mul.sv
src/fe2_mnr.sv
fe6_mul/fe6_mul_sched.sv
src/fe6_mul_top.sv
verif/fe6_mul_assert.sv
verif/fe6_mul_tb.sv

//--- fe6_mul/fe6_mul_sched.sv
// Fp6 multiply scheduler: input capture, 23-step issue, result routing, output serialiser
`timescale 1ns/1ps
`default_nettype none

`include "fe6_defines.svh"

module fe6_mul_sched
  import fe6_pkg::*;
(
  input  wire        i_clk,
  input  wire        i_rst,
  input  wire strm_t i_in,
  output logic       o_in_rdy,
  output strm_t      o_out,
  input  wire        i_out_rdy,
  output strm_t      o_mul_req,
  output strm_t      o_add_req,
  output strm_t      o_sub_req,
  output strm_t      o_mnr_req,
  input  wire strm_t i_mul_rsp,
  input  wire strm_t i_add_rsp,
  input  wire strm_t i_sub_rsp,
  input  wire strm_t i_mnr_rsp,
  output logic       o_err
);

  localparam int N_STEP = 23;
  localparam int N_UNIT = 4;
  // Steps owned by each unit: mul, add, sub, mnr
  localparam logic [31:0] UNIT_MASK [N_UNIT] = '{
    32'h0000_8427, 32'h0048_7318, 32'h0013_08C0, 32'h0024_0000
  };

  fe6_t in_a, in_b, out_q;
  fe2_t aa, bb, cc, t;
  logic [`USER_W-1:0] user_q;
  logic in_done;
  logic [N_STEP-1:0] issued, sent, vld, ready;
  logic [N_UNIT-1:0] busy, go, rsp_ok;
  logic [`TAG_W-1:0] cur [N_UNIT];
  logic [`TAG_W-1:0] pick [N_UNIT];
  logic [`TAG_W-1:0] istep [N_UNIT];
  fe2_t op_a [N_UNIT];
  fe2_t op_b [N_UNIT];
  strm_t req_q [N_UNIT];
  strm_t rsp [N_UNIT];
  out_state_e out_state;
  logic [2:0] out_cnt;

  function automatic logic [`TAG_W-1:0] first_set(input logic [N_STEP-1:0] v);
    logic [`TAG_W-1:0] idx;
    idx = '0;
    for (int i = N_STEP - 1; i >= 0; i--) begin
      if (v[i]) idx = `TAG_W'(i);
    end
    return idx;
  endfunction

  function automatic fe_t comp2(input fe2_t x, input logic hi);
    return hi ? x.im : x.re;
  endfunction

  function automatic fe_t comp6(input fe6_t x, input logic [2:0] k);
    return x[(5 - int'(k)) * `FE_W +: `FE_W];
  endfunction

  // Operand pair {a, b} for a step; mnr steps use a only
  function automatic logic [2*$bits(fe2_t)-1:0] operands(input logic [`TAG_W-1:0] s);
    case (s)
      STEP_AA:      return {in_a.c0, in_b.c0};
      STEP_BB:      return {in_a.c1, in_b.c1};
      STEP_CC:      return {in_a.c2, in_b.c2};
      STEP_T0_A:    return {in_a.c1, in_a.c2};
      STEP_T0_B:    return {in_b.c1, in_b.c2};
      STEP_T0_MUL:  return {out_q.c0, t};
      STEP_T0_SUBB: return {out_q.c0, bb};
      STEP_T0_SUBC: return {out_q.c0, cc};
      STEP_T2_B:    return {in_b.c0, in_b.c2};
      STEP_T2_A:    return {in_a.c0, in_a.c2};
      STEP_T2_MUL:  return {out_q.c2, t};
      STEP_T2_SUBA: return {out_q.c2, aa};
      STEP_T2_ADDB: return {out_q.c2, bb};
      STEP_T1_B:    return {in_b.c0, in_b.c1};
      STEP_T1_A:    return {in_a.c0, in_a.c1};
      STEP_T1_MUL:  return {out_q.c1, t};
      STEP_T1_SUBA: return {out_q.c1, aa};
      STEP_T1_SUBB: return {out_q.c1, bb};
      STEP_C0_MNR:  return {out_q.c0, fe2_t'('0)};
      STEP_C0_FIN:  return {out_q.c0, aa};
      STEP_C2_FIN:  return {out_q.c2, cc};
      STEP_CC_MNR:  return {cc, fe2_t'('0)};
      default:      return {out_q.c1, cc};
    endcase
  endfunction

  // Dependencies, including write-after-read on t and cc
  always_comb begin
    ready = '0;
    ready[STEP_AA]      = in_done;
    ready[STEP_BB]      = in_done;
    ready[STEP_CC]      = in_done;
    ready[STEP_T0_A]    = in_done;
    ready[STEP_T0_B]    = in_done;
    ready[STEP_T0_MUL]  = vld[STEP_T0_A] && vld[STEP_T0_B];
    ready[STEP_T0_SUBB] = vld[STEP_T0_MUL] && vld[STEP_BB];
    ready[STEP_T0_SUBC] = vld[STEP_T0_SUBB] && vld[STEP_CC];
    ready[STEP_T2_B]    = in_done;
    ready[STEP_T2_A]    = in_done && sent[STEP_T0_MUL];
    ready[STEP_T2_MUL]  = vld[STEP_T2_B] && vld[STEP_T2_A];
    ready[STEP_T2_SUBA] = vld[STEP_T2_MUL] && vld[STEP_AA];
    ready[STEP_T2_ADDB] = vld[STEP_T2_SUBA] && vld[STEP_BB];
    ready[STEP_T1_B]    = in_done;
    ready[STEP_T1_A]    = in_done && sent[STEP_T2_MUL];
    ready[STEP_T1_MUL]  = vld[STEP_T1_B] && vld[STEP_T1_A];
    ready[STEP_T1_SUBA] = vld[STEP_T1_MUL] && vld[STEP_AA];
    ready[STEP_T1_SUBB] = vld[STEP_T1_SUBA] && vld[STEP_BB];
    ready[STEP_C0_MNR]  = vld[STEP_T0_SUBC];
    ready[STEP_C0_FIN]  = vld[STEP_C0_MNR] && vld[STEP_AA];
    ready[STEP_C2_FIN]  = vld[STEP_T2_ADDB] && vld[STEP_CC];
    ready[STEP_CC_MNR]  = sent[STEP_C2_FIN] && sent[STEP_T0_SUBC];
    ready[STEP_C1_FIN]  = vld[STEP_T1_SUBB] && vld[STEP_CC_MNR];
  end

  // Step numbers rise with priority order, so the lowest ready step wins
  always_comb begin
    logic [N_STEP-1:0] cand;
    for (int u = 0; u < N_UNIT; u++) begin
      cand     = ready & ~issued & UNIT_MASK[u][N_STEP-1:0];
      go[u]    = !busy[u] && (|cand);
      pick[u]  = first_set(cand);
      istep[u] = busy[u] ? cur[u] : pick[u];
      {op_a[u], op_b[u]} = operands(istep[u]);
      rsp_ok[u] = UNIT_MASK[u][rsp[u].tag];
    end
  end

  assign rsp[0] = i_mul_rsp;
  assign rsp[1] = i_add_rsp;
  assign rsp[2] = i_sub_rsp;
  assign rsp[3] = i_mnr_rsp;

  assign o_mul_req = req_q[0];
  assign o_add_req = req_q[1];
  assign o_sub_req = req_q[2];
  assign o_mnr_req = req_q[3];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_in_rdy  <= 1'b1;
      in_done   <= 1'b0;
      issued    <= '0;
      sent      <= '0;
      vld       <= '0;
      busy      <= '0;
      out_state <= OUT_IDLE;
      out_cnt   <= '0;
      o_err     <= 1'b0;
      for (int u = 0; u < N_UNIT; u++) req_q[u].val <= 1'b0;
    end else begin
      if (i_in.val && o_in_rdy && i_in.eop) begin
        o_in_rdy <= 1'b0;
        in_done  <= 1'b1;
      end
      for (int u = 0; u < N_UNIT; u++) begin
        // Second beat always follows the first in the next cycle
        req_q[u].val <= go[u] || busy[u];
        if (go[u]) begin
          busy[u]         <= 1'b1;
          cur[u]          <= pick[u];
          issued[pick[u]] <= 1'b1;
        end
        if (busy[u]) begin
          busy[u]        <= 1'b0;
          sent[cur[u]]   <= 1'b1;
        end
        if (rsp[u].val) begin
          if (!rsp_ok[u]) o_err <= 1'b1;
          else if (rsp[u].eop) vld[rsp[u].tag] <= 1'b1;
        end
      end
      case (out_state)
        OUT_IDLE: begin
          if (vld[STEP_C1_FIN] && vld[STEP_C2_FIN] && vld[STEP_C0_FIN]) out_state <= OUT_SEND;
        end
        default: begin
          if (i_out_rdy) begin
            out_cnt <= out_cnt + 3'd1;
            if (out_cnt == 3'd5) begin
              out_state <= OUT_IDLE;
              out_cnt   <= '0;
              o_in_rdy  <= 1'b1;
              in_done   <= 1'b0;
              issued    <= '0;
              sent      <= '0;
              vld       <= '0;
            end
          end
        end
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_in.val && o_in_rdy) begin
      in_a <= {in_a[5*`FE_W-1:0], i_in.dat_a};
      in_b <= {in_b[5*`FE_W-1:0], i_in.dat_b};
      if (i_in.eop) user_q <= i_in.user;
    end
    for (int u = 0; u < N_UNIT; u++) begin
      req_q[u].sop   <= !busy[u];
      req_q[u].eop   <= busy[u];
      req_q[u].tag   <= istep[u];
      req_q[u].user  <= '0;
      req_q[u].dat_a <= comp2(op_a[u], busy[u]);
      req_q[u].dat_b <= comp2(op_b[u], busy[u]);
      // Each tag has exactly one destination register
      if (rsp[u].val && rsp_ok[u]) begin
        case (rsp[u].tag)
          STEP_AA: begin
            if (rsp[u].eop) aa.im <= rsp[u].dat_a;
            else aa.re <= rsp[u].dat_a;
          end
          STEP_BB: begin
            if (rsp[u].eop) bb.im <= rsp[u].dat_a;
            else bb.re <= rsp[u].dat_a;
          end
          STEP_CC, STEP_CC_MNR: begin
            if (rsp[u].eop) cc.im <= rsp[u].dat_a;
            else cc.re <= rsp[u].dat_a;
          end
          STEP_T0_B, STEP_T2_A, STEP_T1_A: begin
            if (rsp[u].eop) t.im <= rsp[u].dat_a;
            else t.re <= rsp[u].dat_a;
          end
          STEP_T2_B, STEP_T2_MUL, STEP_T2_SUBA, STEP_T2_ADDB, STEP_C2_FIN: begin
            if (rsp[u].eop) out_q.c2.im <= rsp[u].dat_a;
            else out_q.c2.re <= rsp[u].dat_a;
          end
          STEP_T1_B, STEP_T1_MUL, STEP_T1_SUBA, STEP_T1_SUBB, STEP_C1_FIN: begin
            if (rsp[u].eop) out_q.c1.im <= rsp[u].dat_a;
            else out_q.c1.re <= rsp[u].dat_a;
          end
          default: begin
            if (rsp[u].eop) out_q.c0.im <= rsp[u].dat_a;
            else out_q.c0.re <= rsp[u].dat_a;
          end
        endcase
      end
    end
  end

  // Result stays put until the eop beat leaves, so beats hold under back-pressure
  always_comb begin
    o_out       = '0;
    o_out.val   = (out_state == OUT_SEND);
    o_out.sop   = (out_cnt == 3'd0);
    o_out.eop   = (out_cnt == 3'd5);
    o_out.user  = user_q;
    o_out.dat_a = comp6(out_q, out_cnt);
  end

endmodule

`default_nettype wire

//--- src/fe2_mnr.sv
// Multiply a two-beat Fp2 value by the non-residue 1+u
`timescale 1ns/1ps
`default_nettype none

module fe2_mnr
  import fe6_pkg::*;
(
  input  wire        i_clk,
  input  wire        i_rst,
  input  wire strm_t i_req,
  output strm_t      o_rsp
);

  fe_t a0_q;
  fe_t im_hold;
  logic pend;
  logic fire;

  assign fire = i_req.val && i_req.eop;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend      <= 1'b0;
      o_rsp.val <= 1'b0;
    end else begin
      pend      <= fire;
      o_rsp.val <= fire || pend;
    end
  end

  // (a0 + a1 u)(1 + u) = (a0 - a1) + (a0 + a1) u
  always_ff @(posedge i_clk) begin
    o_rsp.user  <= '0;
    o_rsp.dat_b <= '0;
    if (i_req.val && i_req.sop) a0_q <= i_req.dat_a;
    if (fire) begin
      o_rsp.sop   <= 1'b1;
      o_rsp.eop   <= 1'b0;
      o_rsp.tag   <= i_req.tag;
      o_rsp.dat_a <= mod_sub(a0_q, i_req.dat_a);
      im_hold     <= mod_add(a0_q, i_req.dat_a);
    end else begin
      o_rsp.sop   <= 1'b0;
      o_rsp.eop   <= 1'b1;
      o_rsp.dat_a <= im_hold;
    end
  end

endmodule

`default_nettype wire

//--- src/fe2_mul.sv
// Fp2 multiplier: collects two beats, three-stage product pipeline, two result beats
`timescale 1ns/1ps
`default_nettype none

`include "fe6_defines.svh"

module fe2_mul
  import fe6_pkg::*;
(
  input  wire        i_clk,
  input  wire        i_rst,
  input  wire strm_t i_req,
  output strm_t      o_rsp
);

  localparam int PW = 2 * `FE_W + 1;
  // Offset that keeps a0b0 - a1b1 non-negative
  localparam logic [PW-1:0] P_SQ = PW'(`FE_P) * PW'(`FE_P);

  fe_t a0_q;
  fe_t b0_q;
  logic [2*`FE_W-1:0] p00, p11, p01, p10;
  logic [PW-1:0] re_w, im_w;
  fe_t re_q, im_q, im_hold;
  logic [`TAG_W-1:0] tag1, tag2, tag3;
  logic [2:0] stg_val;
  logic pend;
  logic launch;

  assign launch = i_req.val && i_req.eop;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      stg_val   <= '0;
      pend      <= 1'b0;
      o_rsp.val <= 1'b0;
    end else begin
      stg_val   <= {stg_val[1:0], launch};
      pend      <= stg_val[2];
      o_rsp.val <= stg_val[2] || pend;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_req.val && i_req.sop) begin
      a0_q <= i_req.dat_a;
      b0_q <= i_req.dat_b;
    end
    // Stage 1 partial products, a1 and b1 come straight off the eop beat
    p00  <= a0_q * b0_q;
    p11  <= i_req.dat_a * i_req.dat_b;
    p01  <= a0_q * i_req.dat_b;
    p10  <= i_req.dat_a * b0_q;
    tag1 <= i_req.tag;
    // Stage 2 wide real and imaginary parts
    re_w <= PW'(p00) + P_SQ - PW'(p11);
    im_w <= PW'(p01) + PW'(p10);
    tag2 <= tag1;
    // Stage 3 reduction
    re_q <= fe_t'(re_w % PW'(`FE_P));
    im_q <= fe_t'(im_w % PW'(`FE_P));
    tag3 <= tag2;
  end

  // Jobs are at least two cycles apart, so one hold register is enough
  always_ff @(posedge i_clk) begin
    o_rsp.user  <= '0;
    o_rsp.dat_b <= '0;
    if (stg_val[2]) begin
      o_rsp.sop   <= 1'b1;
      o_rsp.eop   <= 1'b0;
      o_rsp.tag   <= tag3;
      o_rsp.dat_a <= re_q;
      im_hold     <= im_q;
    end else begin
      o_rsp.sop   <= 1'b0;
      o_rsp.eop   <= 1'b1;
      o_rsp.dat_a <= im_hold;
    end
  end

endmodule

`default_nettype wire

//--- src/fe6_mul_top.sv
// Fp6 multiplier top level: scheduler plus its four Fp2 arithmetic units
`timescale 1ns/1ps
`default_nettype none

module fe6_mul_top
  import fe6_pkg::*;
(
  input  wire        i_clk,
  input  wire        i_rst,
  input  wire strm_t i_in,
  output logic       o_in_rdy,
  output strm_t      o_out,
  input  wire        i_out_rdy,
  output logic       o_err
);

  strm_t mul_req, mul_rsp;
  strm_t add_req, add_rsp;
  strm_t sub_req, sub_rsp;
  strm_t mnr_req, mnr_rsp;

  fe6_mul_sched u_sched (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in      (i_in),
    .o_in_rdy  (o_in_rdy),
    .o_out     (o_out),
    .i_out_rdy (i_out_rdy),
    .o_mul_req (mul_req),
    .o_add_req (add_req),
    .o_sub_req (sub_req),
    .o_mnr_req (mnr_req),
    .i_mul_rsp (mul_rsp),
    .i_add_rsp (add_rsp),
    .i_sub_rsp (sub_rsp),
    .i_mnr_rsp (mnr_rsp),
    .o_err     (o_err)
  );

  fe2_mul u_mul (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (mul_req),
    .o_rsp (mul_rsp)
  );

  fe_addsub #(.IS_SUB(0)) u_add (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (add_req),
    .o_rsp (add_rsp)
  );

  fe_addsub #(.IS_SUB(1)) u_sub (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (sub_req),
    .o_rsp (sub_rsp)
  );

  fe2_mnr u_mnr (
    .i_clk (i_clk),
    .i_rst (i_rst),
    .i_req (mnr_req),
    .o_rsp (mnr_rsp)
  );

endmodule

`default_nettype wire

//--- src/fe_addsub.sv
// Two-beat Fp2 modular adder or subtractor, one register stage per beat
`timescale 1ns/1ps
`default_nettype none

module fe_addsub
  import fe6_pkg::*;
#(
  parameter int IS_SUB = 0
) (
  input  wire        i_clk,
  input  wire        i_rst,
  input  wire strm_t i_req,
  output strm_t      o_rsp
);

  fe_t res;

  always_comb begin
    if (IS_SUB != 0) begin
      res = mod_sub(i_req.dat_a, i_req.dat_b);
    end else begin
      res = mod_add(i_req.dat_a, i_req.dat_b);
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rsp.val <= 1'b0;
    end else begin
      o_rsp.val <= i_req.val;
    end
  end

  // Beat framing and tag follow the data through the stage
  always_ff @(posedge i_clk) begin
    o_rsp.sop   <= i_req.sop;
    o_rsp.eop   <= i_req.eop;
    o_rsp.tag   <= i_req.tag;
    o_rsp.user  <= '0;
    o_rsp.dat_a <= res;
    o_rsp.dat_b <= '0;
  end

endmodule

`default_nettype wire

//--- verif/fe6_mul_assert.sv
// Bound protocol assertions for the Fp6 multiplier top level
`timescale 1ns/1ps
`default_nettype none

module fe6_mul_assert
  import fe6_pkg::*;
(
  input wire        i_clk,
  input wire        i_rst,
  input wire strm_t i_in,
  input wire        i_in_rdy,
  input wire strm_t i_out,
  input wire        i_out_rdy,
  input wire        i_err
);

  logic       in_flight;
  logic [2:0] beat_cnt;
  // Assertion failures so far
  int         n_fail = 0;

  // Tracks one operation from its input eop to its output eop
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      in_flight <= 1'b0;
      beat_cnt  <= '0;
    end else begin
      if (i_in.val && i_in_rdy && i_in.eop) in_flight <= 1'b1;
      if (i_out.val && i_out_rdy) begin
        beat_cnt <= (beat_cnt == 3'd5) ? 3'd0 : beat_cnt + 3'd1;
        if (i_out.eop) in_flight <= 1'b0;
      end
    end
  end

  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_out.val && !i_out_rdy) |=> $stable(i_out))
    else begin
      n_fail++;
      $error("o_out changed while stalled by i_out_rdy");
    end

  a_no_err: assert property (@(posedge i_clk) disable iff (i_rst) !i_err)
    else begin
      n_fail++;
      $error("o_err is high");
    end

  a_in_rdy_low: assert property (@(posedge i_clk) disable iff (i_rst)
    in_flight |-> !i_in_rdy)
    else begin
      n_fail++;
      $error("o_in_rdy high while an operation is in flight");
    end

  // First beat carries sop, sixth carries eop
  a_beat_frame: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out.val |-> ((i_out.sop == (beat_cnt == 3'd0)) && (i_out.eop == (beat_cnt == 3'd5))))
    else begin
      n_fail++;
      $error("o_out sop or eop does not match the beat position");
    end

endmodule

`default_nettype wire

//--- verif/fe6_mul_tb.sv
// Fp6 multiplier testbench: clock, reset, random stimulus, reference model, checks, result line
`timescale 1ns/1ps
`default_nettype none

`include "fe6_defines.svh"

module fe6_mul_tb
  import fe6_pkg::*;
();

  localparam longint PRIME   = `FE_P;
  localparam int     TIMEOUT = 2000;

  logic  i_clk;
  logic  i_rst;
  strm_t i_in;
  logic  o_in_rdy;
  strm_t o_out;
  logic  i_out_rdy;
  logic  o_err;

  int n_errors = 0;
  int n_checks = 0;
  int n_ops    = 0;
  bit abort    = 1'b0;

  fe6_mul_top dut (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in      (i_in),
    .o_in_rdy  (o_in_rdy),
    .o_out     (o_out),
    .i_out_rdy (i_out_rdy),
    .o_err     (o_err)
  );

  bind fe6_mul_top fe6_mul_assert u_assert (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_in      (i_in),
    .i_in_rdy  (o_in_rdy),
    .i_out     (o_out),
    .i_out_rdy (i_out_rdy),
    .i_err     (o_err)
  );

  initial i_clk = 1'b0;
  always #10 i_clk = ~i_clk;

  // Reference arithmetic in Fp
  function automatic fe_t p_add(input fe_t x, input fe_t y);
    return fe_t'((longint'(x) + longint'(y)) % PRIME);
  endfunction

  function automatic fe_t p_sub(input fe_t x, input fe_t y);
    return fe_t'((longint'(x) + PRIME - longint'(y)) % PRIME);
  endfunction

  function automatic fe_t p_mul(input fe_t x, input fe_t y);
    return fe_t'((longint'(x) * longint'(y)) % PRIME);
  endfunction

  function automatic fe2_t f2_add(input fe2_t x, input fe2_t y);
    fe2_t r;
    r.re = p_add(x.re, y.re);
    r.im = p_add(x.im, y.im);
    return r;
  endfunction

  // u^2 = -1
  function automatic fe2_t f2_mul(input fe2_t x, input fe2_t y);
    fe2_t r;
    r.re = p_sub(p_mul(x.re, y.re), p_mul(x.im, y.im));
    r.im = p_add(p_mul(x.re, y.im), p_mul(x.im, y.re));
    return r;
  endfunction

  function automatic fe2_t f2_xi(input fe2_t x);
    fe2_t r;
    r.re = p_sub(x.re, x.im);
    r.im = p_add(x.re, x.im);
    return r;
  endfunction

  // Schoolbook product, v^3 folds back as xi
  function automatic fe6_t f6_mul(input fe6_t a, input fe6_t b);
    fe6_t r;
    fe2_t cross0;
    fe2_t cross1;
    cross0 = f2_add(f2_mul(a.c1, b.c2), f2_mul(a.c2, b.c1));
    cross1 = f2_add(f2_mul(a.c0, b.c1), f2_mul(a.c1, b.c0));
    r.c0 = f2_add(f2_mul(a.c0, b.c0), f2_xi(cross0));
    r.c1 = f2_add(cross1, f2_xi(f2_mul(a.c2, b.c2)));
    r.c2 = f2_add(f2_add(f2_mul(a.c0, b.c2), f2_mul(a.c1, b.c1)), f2_mul(a.c2, b.c0));
    return r;
  endfunction

  // Beat k in stream order c0.re, c0.im, c1.re, c1.im, c2.re, c2.im
  function automatic fe_t beat_of(input fe6_t x, input int k);
    case (k)
      0: return x.c0.re;
      1: return x.c0.im;
      2: return x.c1.re;
      3: return x.c1.im;
      4: return x.c2.re;
      default: return x.c2.im;
    endcase
  endfunction

  function automatic fe_t rand_fe();
    return fe_t'($urandom_range(32'(PRIME - 1), 0));
  endfunction

  function automatic fe6_t rand_fe6();
    fe6_t x;
    x.c0.re = rand_fe();
    x.c0.im = rand_fe();
    x.c1.re = rand_fe();
    x.c1.im = rand_fe();
    x.c2.re = rand_fe();
    x.c2.im = rand_fe();
    return x;
  endfunction

  function automatic fe6_t fill_fe6(input fe_t v);
    fe6_t x;
    x.c0.re = v;
    x.c0.im = v;
    x.c1.re = v;
    x.c1.im = v;
    x.c2.re = v;
    x.c2.im = v;
    return x;
  endfunction

  task automatic check_field(input string name, input int beat,
                             input logic [31:0] exp_v, input logic [31:0] got_v);
    n_checks++;
    if (got_v !== exp_v) begin
      n_errors++;
      $display("FAIL t=%0t %s beat %0d: expected %0h, got %0h",
               $time, name, beat, exp_v, got_v);
    end
  endtask

  task automatic check_beat(input int k, input fe6_t exp_r, input logic [`USER_W-1:0] user);
    check_field("o_out.dat_a", k, 32'(beat_of(exp_r, k)), 32'(o_out.dat_a));
    check_field("o_out.dat_b", k, 32'd0, 32'(o_out.dat_b));
    check_field("o_out.sop", k, 32'(k == 0), 32'(o_out.sop));
    check_field("o_out.eop", k, 32'(k == 5), 32'(o_out.eop));
    check_field("o_out.user", k, 32'(user), 32'(o_out.user));
    check_field("o_err", k, 32'd0, 32'(o_err));
  endtask

  // Drives the six input beats, optionally with idle gaps carrying junk data
  task automatic send_op(input fe6_t a, input fe6_t b, input logic [`USER_W-1:0] user,
                         input bit gaps);
    int cnt;
    for (int k = 0; k < 6; k++) begin
      if (gaps && ($urandom % 100) < 30) begin
        i_in.val   = 1'b0;
        i_in.dat_a = fe_t'($urandom);
        i_in.dat_b = fe_t'($urandom);
        repeat (1 + $urandom % 4) @(posedge i_clk);
        #1;
      end
      cnt = 0;
      while (!o_in_rdy && cnt < TIMEOUT) begin
        @(posedge i_clk);
        #1;
        cnt++;
      end
      if (!o_in_rdy) begin
        n_errors++;
        $display("Timeout: o_in_rdy stayed low for %0d cycles in operation %0d", TIMEOUT, n_ops);
        abort  = 1'b1;
        i_in   = '0;
        return;
      end
      i_in.val   = 1'b1;
      i_in.sop   = (k == 0);
      i_in.eop   = (k == 5);
      i_in.tag   = '0;
      // Only the eop beat's user field counts
      i_in.user  = (k == 5) ? user : `USER_W'($urandom);
      i_in.dat_a = beat_of(a, k);
      i_in.dat_b = beat_of(b, k);
      @(posedge i_clk);
      #1;
    end
    i_in = '0;
  endtask

  task automatic recv_op(input fe6_t exp_r, input logic [`USER_W-1:0] user, input int bp_pct);
    int cnt;
    bit got;
    for (int k = 0; k < 6; k++) begin
      cnt = 0;
      got = 1'b0;
      while (!got && cnt < TIMEOUT) begin
        i_out_rdy = (int'($urandom % 100) >= bp_pct);
        if (o_out.val && i_out_rdy) begin
          check_beat(k, exp_r, user);
          got = 1'b1;
        end
        @(posedge i_clk);
        #1;
        cnt++;
      end
      if (!got) begin
        n_errors++;
        $display("Timeout: output beat %0d of operation %0d missing after %0d cycles",
                 k, n_ops, TIMEOUT);
        abort     = 1'b1;
        i_out_rdy = 1'b0;
        return;
      end
    end
    i_out_rdy = 1'b0;
  endtask

  task automatic run_op(input fe6_t a, input fe6_t b, input int bp_pct, input bit gaps);
    logic [`USER_W-1:0] user;
    fe6_t exp_r;
    if (abort) return;
    user  = `USER_W'($urandom);
    exp_r = f6_mul(a, b);
    send_op(a, b, user, gaps);
    if (!abort) recv_op(exp_r, user, bp_pct);
    n_ops++;
  endtask

  task automatic run_random(input int count, input int bp_pct, input bit gaps);
    fe6_t a;
    fe6_t b;
    for (int n = 0; n < count && !abort; n++) begin
      a = rand_fe6();
      b = rand_fe6();
      run_op(a, b, bp_pct, gaps);
    end
  endtask

  initial begin
    fe6_t a;
    fe6_t one;
    void'($urandom(95));
    i_rst     = 1'b1;
    i_in      = '0;
    i_out_rdy = 1'b0;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    @(posedge i_clk);
    #1;

    // Out of reset the input side is open and no output is pending
    if (o_in_rdy !== 1'b1) begin
      n_errors++;
      $display("FAIL t=%0t o_in_rdy: expected 1, got %0b", $time, o_in_rdy);
    end
    if (o_out.val !== 1'b0) begin
      n_errors++;
      $display("FAIL t=%0t o_out.val: expected 0, got %0b", $time, o_out.val);
    end

    run_random(200, 0, 1'b0);

    // Corner operands
    one       = '0;
    one.c0.re = fe_t'(1);
    run_op(fill_fe6('0), rand_fe6(), 0, 1'b0);
    run_op(rand_fe6(), fill_fe6('0), 0, 1'b0);
    run_op(one, rand_fe6(), 0, 1'b0);
    run_op(rand_fe6(), one, 0, 1'b0);
    run_op(one, one, 0, 1'b0);
    run_op(fill_fe6(fe_t'(PRIME - 1)), fill_fe6(fe_t'(PRIME - 1)), 0, 1'b0);
    a = rand_fe6();
    run_op(a, a, 0, 1'b0);

    // Output stalls on about 40% of cycles
    run_random(100, 40, 1'b0);
    // Input idle gaps, then both together
    run_random(100, 0, 1'b1);
    run_random(50, 40, 1'b1);

    if (o_err) begin
      n_errors++;
      $display("o_err is high at the end of the run");
    end
    if (dut.u_assert.n_fail != 0) begin
      n_errors += dut.u_assert.n_fail;
      $display("Protocol assertions failed %0d times", dut.u_assert.n_fail);
    end
    $display("Operations: %0d, checks: %0d, errors: %0d", n_ops, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
